// ==== design/corr_pkg.sv ====
// ---------------------------------------------------------------------------
// Correlator array geometry and accumulator types
// ---------------------------------------------------------------------------
package corr_pkg;

   // Array size
   localparam int N_ANT   = 8;
   localparam int N_PAIRS = N_ANT * (N_ANT - 1) / 2;

   // Counter width, enough for the longest window without overflow
   localparam int COUNT_W = 24;

   // One accumulator count
   typedef logic [COUNT_W-1:0] count_t;

   // One sample, one bit per antenna
   typedef logic [N_ANT-1:0] ant_t;

   // Index of an unordered antenna pair
   typedef logic [4:0] pair_idx_t;

   // Pair number of (a, b) with a < b, in row order
   // (0,1) -> 0, (0,7) -> 6, (1,2) -> 7, ...
   function automatic pair_idx_t pair_idx(input int a, input int b);
      int row_base;
      row_base = a * N_ANT - (a * (a + 1)) / 2;
      return pair_idx_t'(row_base + (b - a - 1));
   endfunction

endpackage

// ==== design/bus_pkg.sv ====
// ---------------------------------------------------------------------------
// Bus widths, unit map and system registers
// ---------------------------------------------------------------------------
package bus_pkg;

   localparam int ADR_W = 11;
   localparam int DAT_W = 32;

   typedef logic [ADR_W-1:0] adr_t;
   typedef logic [DAT_W-1:0] dat_t;

   // Unit number in address bits 10..8, offset below it
   localparam int UNIT_LSB = 8;
   localparam int UNIT_W   = ADR_W - UNIT_LSB;
   localparam int OFF_W    = UNIT_LSB;
   localparam logic [UNIT_W-1:0] UNIT_CORR = 3'd0;
   localparam logic [UNIT_W-1:0] UNIT_ONES = 3'd1;
   localparam logic [UNIT_W-1:0] UNIT_SYS  = 3'd7;

   // Read-port offsets seen by the accumulator units
   localparam int CORR_OFF_W  = 7;
   localparam int ONES_OFF_W  = 3;
   // Sine half starts at offset 32
   localparam int SIN_OFF_BIT = 5;

   // System registers
   localparam logic [OFF_W-1:0] REG_STATUS    = 8'd0;
   localparam logic [OFF_W-1:0] REG_COUNT_MAX = 8'd1;
   localparam int CMAX_W = 16;
   localparam logic [CMAX_W-1:0] COUNT_MAX_RST = 16'd15;

endpackage

// ==== design/quad_delay.sv ====
// ---------------------------------------------------------------------------
// Quadrature stage
// The previous accepted sample stands in for the Hilbert transform
// ---------------------------------------------------------------------------
module quad_delay (
   input  logic            clk_i,
   input  logic            rst,
   input  logic            active_i,
   input  logic            strobe_i,
   input  corr_pkg::ant_t  antenna_i,
   output logic            go_o,
   output corr_pkg::ant_t  re_o,
   output corr_pkg::ant_t  im_o
);

   // Sample accepted this cycle
   logic take;

   assign take = active_i && strobe_i;

   // Valid flag lines up with the registered re/im pair
   always_ff @(posedge clk_i) begin
      if (rst) go_o <= 1'b0;
      else     go_o <= take;
   end

   // re holds the newest sample, im the one before it
   // Both start at zero so the first im is zero
   always_ff @(posedge clk_i) begin
      if (rst) begin
         re_o <= '0;
         im_o <= '0;
      end else if (take) begin
         re_o <= antenna_i;
         im_o <= re_o;
      end
   end

endmodule

// ==== design/acq_control.sv ====
// ---------------------------------------------------------------------------
// Acquisition control
// Activation flag, window counter and bank-swap pulse
// ---------------------------------------------------------------------------
module acq_control (
   input  logic                        clk_i,
   input  logic                        rst,
   input  logic                        enable_i,
   input  logic                        strobe_i,
   input  logic                        go_i,
   input  logic [bus_pkg::CMAX_W-1:0]  count_max_i,
   output logic                        active_o,
   output logic                        swap_o,
   output logic                        switch_o
);

   import bus_pkg::*;

   // Go cycles seen so far in this window
   logic [CMAX_W-1:0] win_cnt;
   logic              win_last;

   // Start on the first valid sample after enable, stop with enable
   always_ff @(posedge clk_i) begin
      if (rst || !enable_i) active_o <= 1'b0;
      else if (strobe_i)    active_o <= 1'b1;
   end

   // Window holds count_max + 1 samples
   // A count_max lowered mid-window ends it on the next sample
   assign win_last = (win_cnt >= count_max_i);
   assign swap_o   = go_i && win_last;

   always_ff @(posedge clk_i) begin
      if (rst)         win_cnt <= '0;
      else if (swap_o) win_cnt <= '0;
      else if (go_i)   win_cnt <= win_cnt + 1'b1;
   end

   // Visible one cycle after the banks swap
   always_ff @(posedge clk_i) begin
      if (rst) switch_o <= 1'b0;
      else     switch_o <= swap_o;
   end

endmodule

// ==== design/correlator_block.sv ====
// ---------------------------------------------------------------------------
// Pairwise correlator
// Cosine and sine counts for every antenna pair, double-buffered
// ---------------------------------------------------------------------------
module correlator_block (
   input  logic                            clk_i,
   input  logic                            rst,
   input  logic                            go_i,
   input  logic                            swap_i,
   input  corr_pkg::ant_t                  re_i,
   input  corr_pkg::ant_t                  im_i,
   input  logic [bus_pkg::CORR_OFF_W-1:0]  rd_off_i,
   output corr_pkg::count_t                rd_dat_o
);

   import corr_pkg::*;
   import bus_pkg::*;

   // Live banks fill during the window
   count_t cos_live [N_PAIRS];
   count_t sin_live [N_PAIRS];
   // Read banks hold the last finished window
   count_t cos_bank [N_PAIRS];
   count_t sin_bank [N_PAIRS];

   // Read port fields
   pair_idx_t rd_idx;
   logic      rd_sin;
   logic      rd_hi;

   // ------------------------------------------------------------------------
   // Accumulators, one cosine and one sine per pair
   // ------------------------------------------------------------------------
   for (genvar a = 0; a < N_ANT - 1; a++) begin : g_row
      for (genvar b = a + 1; b < N_ANT; b++) begin : g_pair
         localparam pair_idx_t P = pair_idx(a, b);

         // Real against real
         logic   hit_cos;
         // Real against imaginary
         logic   hit_sin;
         count_t cos_next;
         count_t sin_next;

         assign hit_cos  = go_i && (re_i[a] == re_i[b]);
         assign hit_sin  = go_i && (re_i[a] == im_i[b]);
         assign cos_next = cos_live[P] + count_t'(hit_cos);
         assign sin_next = sin_live[P] + count_t'(hit_sin);

         always_ff @(posedge clk_i) begin
            if (rst) begin
               cos_live[P] <= '0;
               sin_live[P] <= '0;
               cos_bank[P] <= '0;
               sin_bank[P] <= '0;
            end else if (swap_i) begin
               // Final sample goes into the finished totals
               cos_bank[P] <= cos_next;
               sin_bank[P] <= sin_next;
               cos_live[P] <= '0;
               sin_live[P] <= '0;
            end else begin
               cos_live[P] <= cos_next;
               sin_live[P] <= sin_next;
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Combinational read port
   // ------------------------------------------------------------------------
   // Offset p is cosine, 32 + p is sine
   assign rd_idx = rd_off_i[SIN_OFF_BIT-1:0];
   assign rd_sin = rd_off_i[SIN_OFF_BIT];
   // Anything from offset 64 up is unmapped
   assign rd_hi  = |rd_off_i[CORR_OFF_W-1:SIN_OFF_BIT+1];

   always_comb begin
      if (rd_hi || (rd_idx >= N_PAIRS))
         rd_dat_o = '0;
      else if (rd_sin)
         rd_dat_o = sin_bank[rd_idx];
      else
         rd_dat_o = cos_bank[rd_idx];
   end

endmodule

// ==== design/ones_count.sv ====
// ---------------------------------------------------------------------------
// Ones counter per antenna
// Used downstream for mean estimation, same bank swap as the correlator
// ---------------------------------------------------------------------------
module ones_count (
   input  logic                            clk_i,
   input  logic                            rst,
   input  logic                            go_i,
   input  logic                            swap_i,
   input  corr_pkg::ant_t                  re_i,
   input  logic [bus_pkg::ONES_OFF_W-1:0]  rd_off_i,
   output corr_pkg::count_t                rd_dat_o
);

   import corr_pkg::*;

   count_t ones_live [N_ANT];
   count_t ones_bank [N_ANT];

   for (genvar k = 0; k < N_ANT; k++) begin : g_ant
      count_t ones_next;

      // Add one for each high bit on a go cycle
      assign ones_next = ones_live[k] + count_t'(go_i && re_i[k]);

      always_ff @(posedge clk_i) begin
         if (rst) begin
            ones_live[k] <= '0;
            ones_bank[k] <= '0;
         end else if (swap_i) begin
            ones_bank[k] <= ones_next;
            ones_live[k] <= '0;
         end else begin
            ones_live[k] <= ones_next;
         end
      end
   end

   // Every 3-bit offset maps to an antenna
   assign rd_dat_o = ones_bank[rd_off_i];

endmodule

// ==== design/bus_decode.sv ====
// ---------------------------------------------------------------------------
// Bus decode
// Unit select, acknowledge, read-data latch and system registers
// ---------------------------------------------------------------------------
module bus_decode (
   input  logic                            clk_i,
   input  logic                            rst,
   input  logic                            cyc_i,
   input  logic                            stb_i,
   input  logic                            we_i,
   input  logic                            bst_i,
   input  bus_pkg::adr_t                   adr_i,
   input  bus_pkg::dat_t                   dat_i,
   input  corr_pkg::count_t                corr_dat_i,
   input  corr_pkg::count_t                ones_dat_i,
   input  logic                            active_i,
   input  logic                            swap_i,
   output logic                            ack_o,
   output bus_pkg::dat_t                   dat_o,
   output logic [bus_pkg::CORR_OFF_W-1:0]  corr_off_o,
   output logic [bus_pkg::ONES_OFF_W-1:0]  ones_off_o,
   output logic [bus_pkg::CMAX_W-1:0]      count_max_o
);

   import bus_pkg::*;

   logic              req;
   logic              take;
   logic [UNIT_W-1:0] unit;
   logic [OFF_W-1:0]  off;
   logic              sys_sel;
   logic              unread_data;
   dat_t              rd_word;

   // ------------------------------------------------------------------------
   // Address split and handshake
   // ------------------------------------------------------------------------
   assign req  = cyc_i && stb_i;
   // One ack per request, or one per cycle during a burst
   assign take = req && (!ack_o || bst_i);

   assign unit       = adr_i[ADR_W-1:UNIT_LSB];
   assign off        = adr_i[OFF_W-1:0];
   assign sys_sel    = (unit == UNIT_SYS);
   assign corr_off_o = off[CORR_OFF_W-1:0];
   assign ones_off_o = off[ONES_OFF_W-1:0];

   always_ff @(posedge clk_i) begin
      if (rst) ack_o <= 1'b0;
      else     ack_o <= take;
   end

   // ------------------------------------------------------------------------
   // Read mux, unmapped space reads as zero
   // ------------------------------------------------------------------------
   always_comb begin
      rd_word = '0;
      case (unit)
         UNIT_CORR:
            if (!off[OFF_W-1]) rd_word = dat_t'(corr_dat_i);
         UNIT_ONES:
            if (off[OFF_W-1:ONES_OFF_W] == '0) rd_word = dat_t'(ones_dat_i);
         UNIT_SYS:
            if (off == REG_STATUS)
               rd_word = dat_t'({unread_data, active_i});
            else if (off == REG_COUNT_MAX)
               rd_word = dat_t'(count_max_o);
         default:
            rd_word = '0;
      endcase
   end

   // Latched in the edge that raises ack
   always_ff @(posedge clk_i) begin
      if (take && !we_i) dat_o <= rd_word;
   end

   // ------------------------------------------------------------------------
   // System registers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst)
         count_max_o <= COUNT_MAX_RST;
      else if (take && we_i && sys_sel && (off == REG_COUNT_MAX))
         count_max_o <= dat_i[CMAX_W-1:0];
   end

   // New window wins over a status read in the same cycle
   always_ff @(posedge clk_i) begin
      if (rst)
         unread_data <= 1'b0;
      else if (swap_i)
         unread_data <= 1'b1;
      else if (take && !we_i && sys_sel && (off == REG_STATUS))
         unread_data <= 1'b0;
   end

endmodule

// ==== design/tart_correlator.sv ====
// ---------------------------------------------------------------------------
// Correlator subsystem top level, 8 antennas
// ---------------------------------------------------------------------------
module tart_correlator (
   input  logic            clk_i,
   input  logic            rst,
   // Bus
   input  logic            cyc_i,
   input  logic            stb_i,
   input  logic            we_i,
   input  logic            bst_i,
   output logic            ack_o,
   input  bus_pkg::adr_t   adr_i,
   input  bus_pkg::dat_t   dat_i,
   output bus_pkg::dat_t   dat_o,
   // Sample stream
   input  logic            enable_i,
   input  logic            strobe_i,
   input  corr_pkg::ant_t  antenna_i,
   output logic            switch_o
);

   import corr_pkg::*;
   import bus_pkg::*;

   logic                  active;
   logic                  go;
   ant_t                  re;
   ant_t                  im;
   logic                  swap;
   logic [CMAX_W-1:0]     count_max;
   logic [CORR_OFF_W-1:0] corr_off;
   logic [ONES_OFF_W-1:0] ones_off;
   count_t                corr_dat;
   count_t                ones_dat;

   // ------------------------------------------------------------------------
   // Sample path
   // ------------------------------------------------------------------------
   quad_delay u_quad_delay (
      .clk_i     (clk_i),
      .rst       (rst),
      .active_i  (active),
      .strobe_i  (strobe_i),
      .antenna_i (antenna_i),
      .go_o      (go),
      .re_o      (re),
      .im_o      (im)
   );

   acq_control u_acq_control (
      .clk_i       (clk_i),
      .rst         (rst),
      .enable_i    (enable_i),
      .strobe_i    (strobe_i),
      .go_i        (go),
      .count_max_i (count_max),
      .active_o    (active),
      .swap_o      (swap),
      .switch_o    (switch_o)
   );

   correlator_block u_correlator_block (
      .clk_i    (clk_i),
      .rst      (rst),
      .go_i     (go),
      .swap_i   (swap),
      .re_i     (re),
      .im_i     (im),
      .rd_off_i (corr_off),
      .rd_dat_o (corr_dat)
   );

   // Ones counts only need the real bits
   ones_count u_ones_count (
      .clk_i    (clk_i),
      .rst      (rst),
      .go_i     (go),
      .swap_i   (swap),
      .re_i     (re),
      .rd_off_i (ones_off),
      .rd_dat_o (ones_dat)
   );

   // ------------------------------------------------------------------------
   // Bus side
   // ------------------------------------------------------------------------
   bus_decode u_bus_decode (
      .clk_i       (clk_i),
      .rst         (rst),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .we_i        (we_i),
      .bst_i       (bst_i),
      .adr_i       (adr_i),
      .dat_i       (dat_i),
      .corr_dat_i  (corr_dat),
      .ones_dat_i  (ones_dat),
      .active_i    (active),
      .swap_i      (swap),
      .ack_o       (ack_o),
      .dat_o       (dat_o),
      .corr_off_o  (corr_off),
      .ones_off_o  (ones_off),
      .count_max_o (count_max)
   );

endmodule

// ==== testbench/tb_clock.sv ====
// Free-running clock and synchronous reset for the testbench
module tb_clock #(
   parameter int PERIOD     = 100,
   parameter int RST_CYCLES = 3
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // Reset spans RST_CYCLES rising edges, released on a falling edge
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

// ==== testbench/tb_tart_correlator.sv ====
module tb_tart_correlator;

   import corr_pkg::*;
   import bus_pkg::*;

   localparam int WINDOW_LEN = int'(COUNT_MAX_RST) + 1;
   localparam int ACK_LIMIT  = 20;
   localparam int SW_LIMIT   = 50;
   localparam int RST_LIMIT  = 20;

   logic clk;
   logic rst;
   logic cyc;
   logic stb;
   logic we;
   logic bst;
   logic ack;
   adr_t adr;
   dat_t wdat;
   dat_t rdat;
   logic enable;
   logic strobe;
   ant_t antenna;
   logic switch_sig;

   // Reference counts for the window being sent
   count_t exp_cos [N_PAIRS];
   count_t exp_sin [N_PAIRS];
   count_t exp_ones [N_ANT];
   // Last accepted sample, the model's imaginary part
   ant_t   prev_sample;

   logic [31:0] lcg_state;
   int          checks;
   int          errors;
   int          timeouts;
   event        abort_ev;

   tb_clock #(.PERIOD(100), .RST_CYCLES(3)) u_tb_clock (
      .clk_o (clk),
      .rst_o (rst)
   );

   tart_correlator u_tart_correlator (
      .clk_i     (clk),
      .rst       (rst),
      .cyc_i     (cyc),
      .stb_i     (stb),
      .we_i      (we),
      .bst_i     (bst),
      .ack_o     (ack),
      .adr_i     (adr),
      .dat_i     (wdat),
      .dat_o     (rdat),
      .enable_i  (enable),
      .strobe_i  (strobe),
      .antenna_i (antenna),
      .switch_o  (switch_sig)
   );

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] rand_word();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Top byte of the generator has the best randomness
   function automatic ant_t rand_sample();
      logic [31:0] w;
      w = rand_word();
      return w[31:24];
   endfunction

   // Unit in bits 10..8, offset below
   function automatic adr_t unit_adr(input logic [UNIT_W-1:0] unit, input int off);
      return adr_t'({unit, 8'(off)});
   endfunction

   task automatic check_count(input string name, input count_t got, input count_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_word(input string name, input dat_t got, input dat_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
      end
   endtask

   // Stalls this process so the abort block ends the run in this time step
   task automatic report_timeout(input string what);
      timeouts++;
      $display("Timeout at %0t: %s", $time, what);
      -> abort_ev;
      @(posedge clk);
   endtask

   task automatic wait_reset();
      int cycles;
      cycles = 0;
      while (rst !== 1'b0) begin
         cycles++;
         if (cycles > RST_LIMIT) report_timeout("reset was never released");
         @(negedge clk);
      end
   endtask

   task automatic wait_ack();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (ack !== 1'b1) begin
         cycles++;
         if (cycles > ACK_LIMIT) report_timeout("no bus acknowledge for the request");
         @(negedge clk);
      end
   endtask

   task automatic wait_switch();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (switch_sig !== 1'b1) begin
         cycles++;
         if (cycles > SW_LIMIT) report_timeout("window never ended, no switch pulse");
         @(negedge clk);
      end
      // Pulse lasts a single cycle
      @(negedge clk);
      check_word("switch_o after pulse", dat_t'(switch_sig), '0);
   endtask

   task automatic bus_read(input adr_t a, output dat_t d);
      @(negedge clk);
      cyc = 1'b1;
      stb = 1'b1;
      we  = 1'b0;
      adr = a;
      wait_ack();
      d   = rdat;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   task automatic bus_write(input adr_t a, input dat_t d);
      @(negedge clk);
      cyc  = 1'b1;
      stb  = 1'b1;
      we   = 1'b1;
      adr  = a;
      wdat = d;
      wait_ack();
      cyc  = 1'b0;
      stb  = 1'b0;
      we   = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------------------
   task automatic clear_model();
      for (int p = 0; p < N_PAIRS; p++) begin
         exp_cos[p] = '0;
         exp_sin[p] = '0;
      end
      for (int k = 0; k < N_ANT; k++) exp_ones[k] = '0;
   endtask

   // Pairs numbered row by row, (0,1) first
   task automatic model_accept(input ant_t s);
      int p;
      p = 0;
      for (int a = 0; a < N_ANT - 1; a++) begin
         for (int b = a + 1; b < N_ANT; b++) begin
            exp_cos[p] = exp_cos[p] + count_t'(s[a] == s[b]);
            exp_sin[p] = exp_sin[p] + count_t'(s[a] == prev_sample[b]);
            p++;
         end
      end
      for (int k = 0; k < N_ANT; k++) exp_ones[k] = exp_ones[k] + count_t'(s[k]);
      prev_sample = s;
   endtask

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------
   // First strobe only raises active and is dropped
   task automatic start_acq();
      @(negedge clk);
      enable  = 1'b1;
      strobe  = 1'b1;
      antenna = rand_sample();
   endtask

   task automatic send_window(input int n);
      int   gap;
      ant_t s;
      for (int i = 0; i < n; i++) begin
         gap = int'(rand_word() % 32'd3);
         repeat (gap) begin
            @(negedge clk);
            strobe  = 1'b0;
            antenna = rand_sample();
         end
         s = rand_sample();
         @(negedge clk);
         strobe  = 1'b1;
         antenna = s;
         model_accept(s);
      end
      @(negedge clk);
      strobe = 1'b0;
   endtask

   // Strobes with enable low, none of them may reach the counters
   task automatic send_dropped(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         strobe  = 1'b1;
         antenna = rand_sample();
         @(negedge clk);
         strobe  = 1'b0;
      end
   endtask

   task automatic check_corr_bank();
      dat_t d;
      for (int p = 0; p < N_PAIRS; p++) begin
         bus_read(unit_adr(UNIT_CORR, p), d);
         check_count($sformatf("cos[%0d]", p), count_t'(d), exp_cos[p]);
         bus_read(unit_adr(UNIT_CORR, 32 + p), d);
         check_count($sformatf("sin[%0d]", p), count_t'(d), exp_sin[p]);
      end
   endtask

   task automatic check_ones_bank();
      dat_t d;
      for (int k = 0; k < N_ANT; k++) begin
         bus_read(unit_adr(UNIT_ONES, k), d);
         check_count($sformatf("ones[%0d]", k), count_t'(d), exp_ones[k]);
      end
   endtask

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------
   task automatic test_reset_values();
      dat_t d;
      bus_read(unit_adr(UNIT_SYS, REG_STATUS), d);
      check_word("status", d, '0);
      bus_read(unit_adr(UNIT_SYS, REG_COUNT_MAX), d);
      check_word("count_max", d, dat_t'(COUNT_MAX_RST));
      bus_read(unit_adr(UNIT_CORR, 0), d);
      check_word("cos[0] after reset", d, '0);
   endtask

   task automatic test_registers();
      dat_t d;
      bus_write(unit_adr(UNIT_SYS, REG_COUNT_MAX), 32'd7);
      bus_read(unit_adr(UNIT_SYS, REG_COUNT_MAX), d);
      check_word("count_max", d, 32'd7);
      // Correlator space is read only, even at the count_max offset
      bus_write(unit_adr(UNIT_CORR, REG_COUNT_MAX), 32'h00ab_cdef);
      bus_read(unit_adr(UNIT_CORR, REG_COUNT_MAX), d);
      check_word("cos[1] after write", d, '0);
      bus_read(unit_adr(UNIT_SYS, REG_COUNT_MAX), d);
      check_word("count_max after corr write", d, 32'd7);
      bus_read(unit_adr(3'd3, REG_COUNT_MAX), d);
      check_word("unit 3", d, '0);
      // Back to the default window
      bus_write(unit_adr(UNIT_SYS, REG_COUNT_MAX), dat_t'(COUNT_MAX_RST));
      bus_read(unit_adr(UNIT_SYS, REG_COUNT_MAX), d);
      check_word("count_max restored", d, dat_t'(COUNT_MAX_RST));
   endtask

   task automatic test_window_corr();
      start_acq();
      clear_model();
      send_window(WINDOW_LEN);
      wait_switch();
      check_corr_bank();
   endtask

   task automatic test_window_ones();
      check_ones_bank();
   endtask

   // Bit 0 active, bit 1 unread_data
   task automatic test_status();
      dat_t d;
      bus_read(unit_adr(UNIT_SYS, REG_STATUS), d);
      check_word("status after swap", d, 32'd3);
      bus_read(unit_adr(UNIT_SYS, REG_STATUS), d);
      check_word("status second read", d, 32'd1);
   endtask

   task automatic test_burst_and_disable();
      dat_t d;
      @(negedge clk);
      cyc = 1'b1;
      stb = 1'b1;
      bst = 1'b1;
      we  = 1'b0;
      adr = unit_adr(UNIT_CORR, 0);
      // One new address per cycle, ack stays high for the whole burst
      for (int p = 0; p < N_PAIRS; p++) begin
         @(negedge clk);
         check_word($sformatf("burst ack_o[%0d]", p), dat_t'(ack), 32'd1);
         check_count($sformatf("burst cos[%0d]", p), count_t'(rdat), exp_cos[p]);
         if (p < N_PAIRS - 1) adr = unit_adr(UNIT_CORR, p + 1);
      end
      cyc = 1'b0;
      stb = 1'b0;
      bst = 1'b0;
      @(negedge clk);
      if (ack !== 1'b0) begin
         errors++;
         $display("ack_o still high at %0t after the burst ended", $time);
      end
      // Active drops one cycle after enable
      @(negedge clk);
      enable = 1'b0;
      strobe = 1'b0;
      repeat (2) @(negedge clk);
      bus_read(unit_adr(UNIT_SYS, REG_STATUS), d);
      check_word("status disabled", d, '0);
      send_dropped(5);
      start_acq();
      clear_model();
      send_window(WINDOW_LEN);
      wait_switch();
      check_corr_bank();
      check_ones_bank();
   endtask

   // ------------------------------------------------------------------------
   // Run control
   // ------------------------------------------------------------------------
   initial begin : abort_watch
      @(abort_ev);
      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      $display("sim failed");
      $finish;
   end

   initial begin : main
      cyc         = 1'b0;
      stb         = 1'b0;
      we          = 1'b0;
      bst         = 1'b0;
      adr         = '0;
      wdat        = '0;
      enable      = 1'b0;
      strobe      = 1'b0;
      antenna     = '0;
      lcg_state   = 32'h3409;
      prev_sample = '0;
      checks      = 0;
      errors      = 0;
      timeouts    = 0;
      clear_model();
      wait_reset();
      test_reset_values();
      test_registers();
      test_window_corr();
      test_window_ones();
      test_status();
      test_burst_and_disable();
      $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== build.f ====
design/corr_pkg.sv
design/bus_pkg.sv
design/quad_delay.sv
design/acq_control.sv
design/correlator_block.sv
design/ones_count.sv
design/bus_decode.sv
design/tart_correlator.sv
testbench/tb_clock.sv
testbench/tb_tart_correlator.sv

// ==== Makefile ====
TB_TOP = tb_tart_correlator

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -Wno-fatal --top-module $(TB_TOP) -f build.f -Mdir obj_dir -o sim_tb

run: build
	./obj_dir/sim_tb > sim.log 2>&1; cat sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing --top-module tart_correlator -f build.f

clean:
	rm -rf obj_dir sim.log
